// File: vlog.f
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_unit.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_unit.sv
source/data_mem.sv
source/proc.sv
verif/proc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the proc testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module proc_tb \
   --Mdir obj_dir -o proc_sim \
   -f vlog.f

./obj_dir/proc_sim > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "Simulation result: pass"
else
   echo "Simulation result: fail"
   exit 1
fi

// File: verif/proc_tb.sv
`timescale 1ns/1ps

module proc_tb
   import isa_pkg::*, core_pkg::*;
;

   localparam int IMEM_DEPTH   = 64;
   localparam int DMEM_DEPTH   = 32;
   localparam int PROG_LEN     = 48;
   localparam int RESET_CYCLES = 16;
   localparam int TAIL_CYCLES  = 6;
   localparam int NUM_TESTS    = 5;
   localparam int SEED         = 77949;
   // Cycles per test for load, reset, retirements and a quiet tail
   localparam int TEST_CYCLES  = PROG_LEN + 2 + RESET_CYCLES + 2 + PROG_LEN + TAIL_CYCLES;
   localparam int CYCLE_LIMIT  = NUM_TESTS * TEST_CYCLES * 3 / 2;

   logic       clk;
   logic       arst_n;
   logic       run;
   logic       prog_we;
   logic [5:0] prog_addr;
   instr_u     prog_data;
   retire_t    retire;
   logic       halted;
   logic       err;

   logic [15:0] lfsr;
   instr_u      prog [PROG_LEN];
   retire_t     exp_q [$];
   logic        exp_halt;
   logic        exp_err;
   int          check_errors;
   int          tests_failed;
   int          records_checked;
   int          cycle_count;

   proc #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) uut (
      .clk, .arst_n, .run, .prog_we, .prog_addr, .prog_data, .retire, .halted, .err
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // Galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic logic [15:0] sign_ext6(input logic [5:0] v);
      return {{10{v[5]}}, v};
   endfunction

   task automatic gen_program(input int kind);
      instr_u     w;
      int         sel;
      int         off;
      logic       have_st;
      logic [2:0] st_rs;
      logic [5:0] st_imm;
      have_st = 1'b0;
      st_rs   = '0;
      st_imm  = '0;
      for (int p = 0; p < PROG_LEN; p++) begin
         w = '0;
         if (p == PROG_LEN - 1 || (kind == 4 && p == 20)) begin
            w.i.op = op_halt;
         end else if (p < 8) begin
            // Prologue seeds each register from its own immediate
            w.i.op  = op_addi;
            w.i.rd  = 3'(p);
            w.i.rs  = 3'(p);
            w.i.imm = 6'(rand_bits(6));
         end else if (kind == 5 && p == 24) begin
            w.i.op  = 4'(8 + rand_bits(3));
            w.i.imm = 6'(rand_bits(6));
         end else begin
            sel = (kind == 1) ? 0 : (kind == 3) ? int'(rand_bits(3)) : int'(rand_bits(2));
            case (sel)
               1:       w.i.op = op_addi;
               2:       w.i.op = op_ld;
               3:       w.i.op = op_st;
               4:       w.i.op = op_beqz;
               5:       w.i.op = op_bnez;
               6:       w.i.op = op_j;
               default: w.r.op = op_rtype;
            endcase
            if (w.r.op == op_rtype) begin
               w.r.rd    = 3'(rand_bits(3));
               w.r.rs    = 3'(rand_bits(3));
               w.r.rt    = 3'(rand_bits(3));
               w.r.funct = 3'(rand_bits(3));
            end else begin
               w.i.rd  = 3'(rand_bits(3));
               w.i.rs  = 3'(rand_bits(3));
               w.i.imm = 6'(rand_bits(6));
            end
            if (sel == 3) begin
               have_st = 1'b1;
               st_rs   = w.i.rs;
               st_imm  = w.i.imm;
            end else if (sel == 2 && have_st) begin
               // Load back through the base and offset of the last store
               w.i.rs  = st_rs;
               w.i.imm = st_imm;
            end
            if (sel >= 4 && sel <= 6) begin
               // Forward offsets that never pass the final halt
               off = 1 + int'(rand_bits(3)) % 7;
               if (p + 1 + off > PROG_LEN - 1) begin
                  off = PROG_LEN - 2 - p;
               end
               w.i.imm = 6'(off);
            end
         end
         prog[p] = w;
      end
   endtask

   // ISA reference model that fills the expected retire queue
   task automatic run_model();
      logic [15:0] regs [8];
      logic [15:0] dmem [DMEM_DEPTH];
      int          pc;
      instr_u      w;
      retire_t     rec;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] res;
      logic [15:0] addr;
      logic        done;
      logic        taken;
      for (int r = 0; r < 8; r++) begin
         regs[r] = '0;
      end
      for (int m = 0; m < DMEM_DEPTH; m++) begin
         dmem[m] = '0;
      end
      exp_q.delete();
      exp_halt = 1'b0;
      exp_err  = 1'b0;
      pc       = 0;
      done     = 1'b0;
      while (!done) begin
         w     = prog[pc];
         rec   = '0;
         rec.valid = 1'b1;
         rec.pc    = 8'(pc);
         a     = regs[w.r.rs];
         b     = regs[w.r.rt];
         addr  = a + sign_ext6(w.i.imm);
         taken = 1'b0;
         case (w.r.op)
            op_rtype: begin
               case (w.r.funct)
                  3'd0:    res = a + b;
                  3'd1:    res = a - b;
                  3'd2:    res = a & b;
                  3'd3:    res = a | b;
                  3'd4:    res = a ^ b;
                  3'd5:    res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                  3'd6:    res = a << 1;
                  default: res = a >> 1;
               endcase
               rec.reg_wr = 1'b1;
               rec.wr_data = res;
            end
            op_addi: begin
               rec.reg_wr  = 1'b1;
               rec.wr_data = addr;
            end
            op_ld: begin
               rec.reg_wr  = 1'b1;
               rec.wr_data = dmem[addr % DMEM_DEPTH];
            end
            op_st: begin
               rec.mem_wr   = 1'b1;
               rec.mem_addr = addr[7:0];
               rec.mem_data = regs[w.i.rd];
               dmem[addr % DMEM_DEPTH] = regs[w.i.rd];
            end
            op_beqz: taken = (a == 16'd0);
            op_bnez: taken = (a != 16'd0);
            op_j:    taken = 1'b1;
            op_halt: begin
               exp_halt = 1'b1;
               done     = 1'b1;
            end
            default: begin
               exp_err = 1'b1;
               done    = 1'b1;
            end
         endcase
         if (rec.reg_wr) begin
            rec.wr_reg     = w.r.rd;
            regs[w.r.rd]   = rec.wr_data;
         end
         if (!exp_err) begin
            exp_q.push_back(rec);
         end
         pc = taken ? (pc + 1 + int'(w.i.imm)) % IMEM_DEPTH : (pc + 1) % IMEM_DEPTH;
      end
   endtask

   task automatic compare_field(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
      assert (got == exp) else begin
         $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
         check_errors++;
      end
   endtask

   task automatic compare_record(input retire_t exp);
      compare_field("retire.pc", 16'(retire.pc), 16'(exp.pc));
      compare_field("retire.reg_wr", 16'(retire.reg_wr), 16'(exp.reg_wr));
      compare_field("retire.mem_wr", 16'(retire.mem_wr), 16'(exp.mem_wr));
      if (exp.reg_wr) begin
         compare_field("retire.wr_reg", 16'(retire.wr_reg), 16'(exp.wr_reg));
         compare_field("retire.wr_data", retire.wr_data, exp.wr_data);
      end
      if (exp.mem_wr) begin
         compare_field("retire.mem_addr", 16'(retire.mem_addr), 16'(exp.mem_addr));
         compare_field("retire.mem_data", retire.mem_data, exp.mem_data);
      end
      records_checked++;
   endtask

   task automatic load_program();
      for (int p = 0; p < PROG_LEN; p++) begin
         @(posedge clk);
         #1;
         prog_we   = 1'b1;
         prog_addr = 6'(p);
         prog_data = prog[p];
      end
      @(posedge clk);
      #1;
      prog_we = 1'b0;
   endtask

   task automatic run_test(input int num, input string name);
      int errs_before;
      errs_before     = check_errors;
      records_checked = 0;
      gen_program(num);
      run_model();
      load_program();
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      run    = 1'b1;
      while (exp_q.size() > 0) begin
         @(posedge clk);
         #1;
         if (retire.valid) begin
            compare_record(exp_q.pop_front());
         end
      end
      // Core must stay quiet once stopped while run is still high
      repeat (TAIL_CYCLES) begin
         @(posedge clk);
         #1;
         assert (!retire.valid) else begin
            $display("Valid retire record at pc %h after the core should have stopped",
                     retire.pc);
            check_errors++;
         end
      end
      compare_field("halted", 16'(halted), 16'(exp_halt));
      compare_field("err", 16'(err), 16'(exp_err));
      run = 1'b0;
      if (check_errors != errs_before) tests_failed++;
      $display("Test %0d %s: %s, %0d records checked", num, name,
               (check_errors == errs_before) ? "pass" : "fail", records_checked);
   endtask

   initial begin
      arst_n       = 1'b0;
      run          = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      lfsr         = SEED[15:0];
      check_errors = 0;
      tests_failed = 0;
      cycle_count  = 0;
      run_test(1, "register operations");
      run_test(2, "immediates, loads and stores");
      run_test(3, "branches and jumps");
      run_test(4, "halt");
      run_test(5, "illegal opcode");
      $display("Tests run %0d, tests failed %0d, failed checks %0d",
               NUM_TESTS, tests_failed, check_errors);
      if (tests_failed == 0 && check_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: source/proc.sv
`timescale 1ns/1ps

module proc
   import isa_pkg::*, core_pkg::*;
#(
   parameter int  IMEM_DEPTH = 64,
   parameter int  DMEM_DEPTH = 32,
   localparam int PC_W       = $clog2(IMEM_DEPTH)
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            run,
   input  logic            prog_we,
   input  logic [PC_W-1:0] prog_addr,
   input  instr_u          prog_data,
   output retire_t         retire,
   output logic            halted,
   output logic            err
);

   logic [15:0] pc;
   instr_u      instr;
   logic        step;
   ctrl_t       ctrl;
   logic [15:0] imm_ext;
   logic [2:0]  rd_addr_b;
   logic [15:0] rd_data_a;
   logic [15:0] rd_data_b;
   logic        redirect;
   logic [15:0] target;
   logic [15:0] mem_addr;
   logic [15:0] mem_wdata;
   logic [15:0] mem_rdata;
   logic        mem_wr;
   logic        wr_en;
   logic [15:0] wr_data;

   fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
      .clk, .arst_n, .run,
      .prog_we, .prog_addr, .prog_data,
      .redirect, .target, .ctrl,
      .pc, .instr, .step, .halted, .err
   );

   inst_decode u_decode (
      .instr, .ctrl, .imm_ext, .rd_addr_b
   );

   reg_file u_regs (
      .clk, .arst_n, .step,
      .rd_addr_a(instr.r.rs),
      .rd_addr_b,
      .wr_en,
      .wr_reg(instr.r.rd),
      .wr_data,
      .rd_data_a, .rd_data_b
   );

   exec_unit u_exec (
      .ctrl, .pc,
      .opnd_a(rd_data_a),
      .opnd_b(rd_data_b),
      .imm_ext, .mem_rdata,
      .redirect, .target, .mem_addr, .mem_wdata, .mem_wr, .wr_en, .wr_data
   );

   data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
      .clk, .arst_n, .step,
      .wr(mem_wr), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
   );

   // Trace of the instruction that commits on this edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         retire <= '0;
      end else begin
         retire.valid    <= step & ~ctrl.illegal;
         retire.pc       <= pc[7:0];
         retire.reg_wr   <= wr_en;
         retire.wr_reg   <= instr.r.rd;
         retire.wr_data  <= wr_data;
         retire.mem_wr   <= mem_wr;
         retire.mem_addr <= mem_addr[7:0];
         retire.mem_data <= mem_wdata;
      end
   end

endmodule

// File: source/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
   parameter int DMEM_DEPTH = 32
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        step,
   input  logic        wr,
   input  logic [15:0] addr,
   input  logic [15:0] wdata,
   output logic [15:0] rdata
);

   localparam int AW = $clog2(DMEM_DEPTH);

   logic [15:0]   mem [DMEM_DEPTH];
   logic [AW-1:0] idx;

   // Upper address bits are ignored
   assign idx = addr[AW-1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (step && wr) begin
         mem[idx] <= wdata;
      end
   end

   assign rdata = mem[idx];

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
   import core_pkg::*;
(
   input  ctrl_t       ctrl,
   input  logic [15:0] pc,
   input  logic [15:0] opnd_a,
   input  logic [15:0] opnd_b,
   input  logic [15:0] imm_ext,
   input  logic [15:0] mem_rdata,
   output logic        redirect,
   output logic [15:0] target,
   output logic [15:0] mem_addr,
   output logic [15:0] mem_wdata,
   output logic        mem_wr,
   output logic        wr_en,
   output logic [15:0] wr_data
);

   logic [15:0] alu_b;
   logic [15:0] alu_res;
   logic        a_zero;

   assign alu_b = ctrl.use_imm ? imm_ext : opnd_b;

   always_comb begin
      case (ctrl.alu_op)
         alu_add, alu_addi, alu_addr: alu_res = opnd_a + alu_b;
         alu_sub:  alu_res = opnd_a - alu_b;
         alu_and:  alu_res = opnd_a & alu_b;
         alu_or:   alu_res = opnd_a | alu_b;
         alu_xor:  alu_res = opnd_a ^ alu_b;
         alu_slt:  alu_res = {15'd0, $signed(opnd_a) < $signed(alu_b)};
         // Shifts move rs by one place
         alu_sll:  alu_res = {opnd_a[14:0], 1'b0};
         alu_srl:  alu_res = {1'b0, opnd_a[15:1]};
         default:  alu_res = '0;
      endcase
   end

   // Branch condition tests rs against zero
   assign a_zero = (opnd_a == '0);

   assign redirect = ctrl.is_jump
                   | (ctrl.is_beqz & a_zero)
                   | (ctrl.is_bnez & ~a_zero);

   // Relative to the following instruction
   assign target = pc + 16'd1 + imm_ext;

   assign mem_addr  = alu_res;
   assign mem_wdata = opnd_b;
   assign mem_wr    = ctrl.mem_wr;

   // Writeback value select
   assign wr_en   = ctrl.reg_wr;
   assign wr_data = ctrl.mem_rd ? mem_rdata : alu_res;

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        step,
   input  logic [2:0]  rd_addr_a,
   input  logic [2:0]  rd_addr_b,
   input  logic        wr_en,
   input  logic [2:0]  wr_reg,
   input  logic [15:0] wr_data,
   output logic [15:0] rd_data_a,
   output logic [15:0] rd_data_b
);

   logic [15:0] regs [8];

   // r0 is a normal register here
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (step && wr_en) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // Reads see the value before this edge's write
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

endmodule

// File: source/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
   import isa_pkg::*, core_pkg::*;
(
   input  instr_u      instr,
   output ctrl_t       ctrl,
   output logic [15:0] imm_ext,
   output logic [2:0]  rd_addr_b
);

   logic [15:0] imm_sext;

   assign imm_sext = {{10{instr.i.imm[5]}}, instr.i.imm};

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = alu_zero;
      imm_ext     = '0;
      rd_addr_b   = instr.r.rt;

      case (instr.r.op)
         op_rtype: begin
            ctrl.reg_wr = 1'b1;
            case (funct_e'(instr.r.funct))
               fn_add:  ctrl.alu_op = alu_add;
               fn_sub:  ctrl.alu_op = alu_sub;
               fn_and:  ctrl.alu_op = alu_and;
               fn_or:   ctrl.alu_op = alu_or;
               fn_xor:  ctrl.alu_op = alu_xor;
               fn_slt:  ctrl.alu_op = alu_slt;
               fn_sll:  ctrl.alu_op = alu_sll;
               default: ctrl.alu_op = alu_srl;
            endcase
         end
         op_addi: begin
            ctrl.alu_op  = alu_addi;
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
            imm_ext      = imm_sext;
         end
         op_ld: begin
            ctrl.alu_op  = alu_addr;
            ctrl.use_imm = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.mem_rd  = 1'b1;
            imm_ext      = imm_sext;
         end
         op_st: begin
            // Store data comes from the rd field
            ctrl.alu_op  = alu_addr;
            ctrl.use_imm = 1'b1;
            ctrl.mem_wr  = 1'b1;
            imm_ext      = imm_sext;
            rd_addr_b    = instr.i.rd;
         end
         op_beqz: begin
            ctrl.is_beqz = 1'b1;
            imm_ext      = imm_sext;
         end
         op_bnez: begin
            ctrl.is_bnez = 1'b1;
            imm_ext      = imm_sext;
         end
         op_j: begin
            ctrl.is_jump = 1'b1;
            imm_ext      = imm_sext;
         end
         op_halt: begin
            ctrl.is_halt = 1'b1;
         end
         default: begin
            // Write bits stay clear
            ctrl.illegal = 1'b1;
         end
      endcase
   end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
   import isa_pkg::*, core_pkg::*;
#(
   parameter int  IMEM_DEPTH = 64,
   localparam int PC_W       = $clog2(IMEM_DEPTH)
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            run,
   input  logic            prog_we,
   input  logic [PC_W-1:0] prog_addr,
   input  instr_u          prog_data,
   input  logic            redirect,
   input  logic [15:0]     target,
   input  ctrl_t           ctrl,
   output logic [15:0]     pc,
   output instr_u          instr,
   output logic            step,
   output logic            halted,
   output logic            err
);

   instr_u          imem [IMEM_DEPTH];
   logic [PC_W-1:0] pc_q;
   logic [PC_W-1:0] pc_next;

   // Program load port, only while the core is stopped
   always_ff @(posedge clk) begin
      if (prog_we && !run) begin
         imem[prog_addr] <= prog_data;
      end
   end

   assign instr = imem[pc_q];
   assign pc    = 16'(pc_q);

   // One instruction per edge unless stopped
   assign step = run & ~halted & ~err;

   // Target is truncated so the pc wraps modulo IMEM_DEPTH
   assign pc_next = redirect ? target[PC_W-1:0] : pc_q + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q   <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (step) begin
         // Illegal word does not commit, pc stays on it
         if (!ctrl.illegal) begin
            pc_q <= pc_next;
         end
         if (ctrl.is_halt) begin
            halted <= 1'b1;
         end
         if (ctrl.illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

// File: source/core_pkg.sv
package core_pkg;

   // ALU function; the first eight follow the funct encoding
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_slt  = 4'd5,
      alu_sll  = 4'd6,
      alu_srl  = 4'd7,
      alu_addi = 4'd8,
      alu_addr = 4'd9,
      alu_zero = 4'd10
   } alu_op_e;

   // Decoded control for one instruction
   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    reg_wr;
      logic    mem_rd;
      logic    mem_wr;
      logic    is_beqz;
      logic    is_bnez;
      logic    is_jump;
      logic    is_halt;
      logic    illegal;
   } ctrl_t;

   // One record per retired instruction
   typedef struct packed {
      logic        valid;
      logic [7:0]  pc;
      logic        reg_wr;
      logic [2:0]  wr_reg;
      logic [15:0] wr_data;
      logic        mem_wr;
      logic [7:0]  mem_addr;
      logic [15:0] mem_data;
   } retire_t;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

   // Major opcode in bits 15:12, values 8 to 15 are not defined
   typedef enum logic [3:0] {
      op_rtype = 4'h0,
      op_addi  = 4'h1,
      op_ld    = 4'h2,
      op_st    = 4'h3,
      op_beqz  = 4'h4,
      op_bnez  = 4'h5,
      op_j     = 4'h6,
      op_halt  = 4'h7
   } opcode_e;

   // Register operations selected by funct
   typedef enum logic [2:0] {
      fn_add = 3'd0,
      fn_sub = 3'd1,
      fn_and = 3'd2,
      fn_or  = 3'd3,
      fn_xor = 3'd4,
      fn_slt = 3'd5,
      fn_sll = 3'd6,
      fn_srl = 3'd7
   } funct_e;

   // Register format: rd = rs op rt
   typedef struct packed {
      logic [3:0] op;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] funct;
   } r_fmt_t;

   // Immediate format, imm is a signed word offset
   typedef struct packed {
      logic [3:0]        op;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } i_fmt_t;

   // Same 16-bit word seen through either format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage
